//--- verilog/obj_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Sprite engine shared definitions
// Sizes, table entry layout, FSM states
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package obj_pkg;

    // Words per table entry, fixed by the layout below
    localparam int OBJ_WORDS = 4;
    // Bits per pixel, colour 0 is transparent
    localparam int PIX_W = 4;
    // Every sprite is this wide
    localparam int SPR_W = 16;

    // Word index inside one table entry
    typedef enum logic [1:0] {
        W_POS_Y = 2'd0,
        W_POS_X = 2'd1,
        W_ROM   = 2'd2,
        W_SPARE = 2'd3
    } obj_word_e;

    // Word 0: height minus one on top of y
    typedef struct packed {
        logic [6:0] hgt;
        logic [8:0] ypos;
    } obj_w0_t;

    // Word 1: enable, spare bit, hflip, palette, x
    typedef struct packed {
        logic       en;
        logic       spare;
        logic       hflip;
        logic [3:0] pal;
        logic [8:0] xpos;
    } obj_w1_t;

    typedef enum logic [1:0] {SC_IDLE, SC_READ, SC_TEST, SC_ISSUE} scan_state_e;

    typedef enum logic [1:0] {DR_IDLE, DR_FETCH, DR_EXPAND} draw_state_e;

    // Line buffer pixel, palette in the upper nibble
    typedef struct packed {
        logic [3:0]       pal;
        logic [PIX_W-1:0] col;
    } pxl_t;

endpackage

`default_nettype wire

//--- verilog/obj_ifs.sv
// ~~~~~~~~~~~~~~~~~~~~
// Sprite engine interfaces
// CPU bus and draw command channel
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

// Wishbone classic, 16-bit data
interface obj_bus_if #(parameter int AW = 6) ();
    logic          cyc;
    logic          stb;
    logic          we;
    logic [AW-1:0] adr;
    logic [15:0]   dat_w;
    logic [15:0]   dat_r;
    logic          ack;

    modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack);
    modport slave  (input cyc, stb, we, adr, dat_w, output dat_r, ack);
endinterface

// Scan to draw, transfer when valid and ready both high
interface obj_cmd_if ();
    logic        valid;
    logic        ready;
    logic [8:0]  xpos;
    logic [15:0] rom_addr;
    logic [3:0]  pal;
    logic        hflip;

    modport source (output valid, xpos, rom_addr, pal, hflip, input ready);
    modport sink   (input valid, xpos, rom_addr, pal, hflip, output ready);
endinterface

`default_nettype wire

//--- verilog/obj_table.sv
// ~~~~~~~~~~~~~~~~~~~~
// Object table RAM
// Wishbone slave for the CPU, synchronous read port for the scan
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module obj_table
    import obj_pkg::*;
#(
    parameter  int OBJ_COUNT = 16,
    localparam int AW        = $clog2(OBJ_COUNT * OBJ_WORDS)
) (
    input  logic          clk,
    input  logic          arst_n,

    // CPU side
    obj_bus_if.slave      bus,

    // Scan side, data one cycle after the address
    input  logic [AW-1:0] tbl_addr,
    output logic [15:0]   tbl_data
);

    localparam int DEPTH = OBJ_COUNT * OBJ_WORDS;

    logic [15:0] mem [DEPTH];
    logic        bus_req;

    // New request only while no ack is out
    // so a held stb gets a single-cycle ack
    assign bus_req = bus.cyc && bus.stb && !bus.ack;

    // Ack generator
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus_req;
        end
    end

    // CPU port of the RAM
    always_ff @(posedge clk) begin
        if (bus_req && bus.we) begin
            mem[bus.adr] <= bus.dat_w;
        end
        // Read data lines up with ack
        if (bus_req) begin
            bus.dat_r <= mem[bus.adr];
        end
    end

    // Scan port, never stalls
    always_ff @(posedge clk) begin
        tbl_data <= mem[tbl_addr];
    end

endmodule

`default_nettype wire

//--- verilog/obj_scan.sv
// ~~~~~~~~~~~~~~~~~~~~
// Object table walker
// Tests each entry against the line, issues draw commands
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module obj_scan
    import obj_pkg::*;
#(
    parameter  int OBJ_COUNT = 16,
    localparam int IDX_W     = $clog2(OBJ_COUNT),
    localparam int AW        = $clog2(OBJ_COUNT * OBJ_WORDS)
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          line_start,
    input  logic [8:0]    line,

    // Table read port
    output logic [AW-1:0] tbl_addr,
    input  logic [15:0]   tbl_data,

    // To draw stage
    obj_cmd_if.source     cmd
);

    localparam logic [IDX_W-1:0] LAST = IDX_W'(OBJ_COUNT - 1);

    scan_state_e      state;
    obj_word_e        wsel;
    logic [IDX_W-1:0] idx;
    logic             start_q;
    logic [8:0]       line_q;
    obj_w0_t          w0_q;
    obj_w1_t          w1_q;
    logic [8:0]       row;
    logic             keep;
    logic             advance;

    assign tbl_addr = {idx, wsel};

    // Row inside the sprite, wraps modulo 512
    assign row  = line_q - w0_q.ypos;
    assign keep = w1_q.en && (row <= {2'b00, w0_q.hgt});

    // Move on after a rejected entry or an accepted command
    assign advance = (state == SC_TEST && !keep) || (state == SC_ISSUE && cmd.ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= SC_IDLE;
            wsel      <= W_POS_Y;
            idx       <= LAST;
            start_q   <= 1'b0;
            cmd.valid <= 1'b0;
        end else begin
            start_q <= line_start;
            if (line_start) begin
                // Walk from the last entry, restarts any walk in progress
                state     <= SC_READ;
                wsel      <= W_POS_Y;
                idx       <= LAST;
                cmd.valid <= 1'b0;
            end else if (advance) begin
                cmd.valid <= 1'b0;
                wsel      <= W_POS_Y;
                if (idx == '0) begin
                    state <= SC_IDLE;
                end else begin
                    idx   <= idx - 1'b1;
                    state <= SC_READ;
                end
            end else begin
                case (state)
                    SC_READ: begin
                        case (wsel)
                            W_POS_Y: wsel  <= W_POS_X;
                            W_POS_X: wsel  <= W_ROM;
                            default: state <= SC_TEST;
                        endcase
                    end
                    // Kept entry, present it
                    SC_TEST: begin
                        cmd.valid <= 1'b1;
                        state     <= SC_ISSUE;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Entry words and command fields
    always_ff @(posedge clk) begin
        // Line sampled in the first walk cycle
        if (start_q) begin
            line_q <= line;
        end
        // Table data trails the address by a cycle
        if (state == SC_READ && wsel == W_POS_X) begin
            w0_q <= obj_w0_t'(tbl_data);
        end
        if (state == SC_READ && wsel == W_ROM) begin
            w1_q <= obj_w1_t'(tbl_data);
        end
        // Word 2 is on tbl_data during TEST
        if (state == SC_TEST) begin
            cmd.xpos     <= w1_q.xpos;
            cmd.pal      <= w1_q.pal;
            cmd.hflip    <= w1_q.hflip;
            cmd.rom_addr <= tbl_data + {6'd0, row, 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- verilog/obj_draw.sv
// ~~~~~~~~~~~~~~~~~~~~
// Sprite row draw stage
// Fetches two ROM words and writes the visible pixels to the line buffer
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module obj_draw
    import obj_pkg::*;
#(
    parameter int LINE_W = 256
) (
    input  logic        clk,
    input  logic        arst_n,

    // From scan stage
    obj_cmd_if.sink     cmd,

    // Pixel ROM, cs held until ok
    output logic        rom_cs,
    output logic [15:0] rom_addr,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,

    // Line buffer write port
    output logic        bf_we,
    output logic [8:0]  bf_addr,
    output pxl_t        bf_data
);

    draw_state_e      state;
    logic             half;
    logic [2:0]       nib;
    logic [31:0]      data_q;
    logic [8:0]       xpos_q;
    logic [3:0]       pal_q;
    logic             hflip_q;
    logic [3:0]       col;
    logic [9:0]       dst;
    logic [PIX_W-1:0] colour;
    logic             visible;

    // One command at a time
    assign cmd.ready = (state == DR_IDLE);

    // Sprite column, word 0 holds columns 0 to 7
    assign col    = {half, nib};
    // Current pixel always in the low nibble
    assign colour = data_q[PIX_W-1:0];

    // Ten bits so that x near the edge clips and never wraps
    assign dst = hflip_q ? {1'b0, xpos_q} + 10'(SPR_W - 1) - {6'd0, col}
                         : {1'b0, xpos_q} + {6'd0, col};

    // Transparent or off-screen pixels still take their cycle
    assign visible = (colour != '0) && (dst < 10'(LINE_W));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= DR_IDLE;
            rom_cs <= 1'b0;
            bf_we  <= 1'b0;
            half   <= 1'b0;
            nib    <= '0;
        end else begin
            bf_we <= 1'b0;
            case (state)
                DR_IDLE: begin
                    if (cmd.valid) begin
                        rom_cs <= 1'b1;
                        half   <= 1'b0;
                        state  <= DR_FETCH;
                    end
                end
                // Wait for the ROM, variable latency
                DR_FETCH: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        nib    <= '0;
                        state  <= DR_EXPAND;
                    end
                end
                DR_EXPAND: begin
                    bf_we <= visible;
                    nib   <= nib + 1'b1;
                    if (nib == 3'd7) begin
                        if (!half) begin
                            // Second word of the row
                            half   <= 1'b1;
                            rom_cs <= 1'b1;
                            state  <= DR_FETCH;
                        end else begin
                            state <= DR_IDLE;
                        end
                    end
                end
                default: state <= DR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DR_IDLE && cmd.valid) begin
            xpos_q   <= cmd.xpos;
            pal_q    <= cmd.pal;
            hflip_q  <= cmd.hflip;
            rom_addr <= cmd.rom_addr;
        end
        if (state == DR_FETCH && rom_ok) begin
            data_q <= rom_data;
        end
        if (state == DR_EXPAND) begin
            data_q  <= data_q >> PIX_W;
            bf_addr <= dst[8:0];
            bf_data <= '{pal: pal_q, col: colour};
            // Next word follows right after the first
            if (nib == 3'd7 && !half) begin
                rom_addr <= rom_addr + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/obj_line_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~
// Ping-pong line buffer
// Back bank takes draws, front bank is read out and erased
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module obj_line_buffer
    import obj_pkg::*;
#(
    parameter  int LINE_W = 256,
    localparam int AW     = $clog2(LINE_W)
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       line_start,
    input  logic       pxl_cen,
    input  logic       bf_we,
    input  logic [8:0] bf_addr,
    input  pxl_t       bf_data,
    output pxl_t       pxl
);

    logic          bank;
    logic [8:0]    rd_cnt;
    logic          rd_hit;
    logic          draw_we;
    logic          clr_busy;
    logic [AW-1:0] clr_cnt;
    pxl_t          rd_pix [2];

    // Out-of-range reads give 0 and erase nothing
    assign rd_hit  = pxl_cen && ({1'b0, rd_cnt} < 10'(LINE_W));
    assign draw_we = bf_we && ({1'b0, bf_addr} < 10'(LINE_W));

    for (genvar b = 0; b < 2; b++) begin : g_bank
        pxl_t          mem [LINE_W];
        logic          sel_back;
        logic          we;
        logic [AW-1:0] addr;
        pxl_t          wdata;

        // bank names the back buffer
        assign sel_back = (bank == 1'(b));
        assign we       = clr_busy || (sel_back ? draw_we : rd_hit);
        assign addr     = clr_busy ? clr_cnt
                        : sel_back ? bf_addr[AW-1:0] : rd_cnt[AW-1:0];
        // Front bank only ever writes zeros
        assign wdata    = (clr_busy || !sel_back) ? '0 : bf_data;

        always_ff @(posedge clk) begin
            if (we) begin
                mem[addr] <= wdata;
            end
        end

        assign rd_pix[b] = mem[rd_cnt[AW-1:0]];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bank     <= 1'b0;
            rd_cnt   <= '0;
            pxl      <= '0;
            clr_busy <= 1'b1;
            clr_cnt  <= '0;
        end else begin
            // Blank both banks once after reset
            if (clr_busy) begin
                clr_cnt <= clr_cnt + 1'b1;
                if (clr_cnt == AW'(LINE_W - 1)) begin
                    clr_busy <= 1'b0;
                end
            end
            if (line_start) begin
                bank   <= ~bank;
                rd_cnt <= '0;
            end else if (pxl_cen) begin
                pxl    <= rd_hit ? rd_pix[~bank] : '0;
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/obj_engine.sv
// ~~~~~~~~~~~~~~~~~~~~
// Sprite engine top level
// Table, scan, draw and line buffer in a row
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module obj_engine
    import obj_pkg::*;
#(
    parameter  int OBJ_COUNT = 16,
    parameter  int LINE_W    = 256,
    localparam int TBL_AW    = $clog2(OBJ_COUNT * OBJ_WORDS)
) (
    input  logic              clk,
    input  logic              arst_n,

    // CPU, Wishbone classic
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [TBL_AW-1:0] wb_adr,
    input  logic [15:0]       wb_dat_w,
    output logic [15:0]       wb_dat_r,
    output logic              wb_ack,

    // Video timing
    input  logic              line_start,
    input  logic [8:0]        line,
    input  logic              pxl_cen,

    // Pixel ROM
    output logic              rom_cs,
    output logic [15:0]       rom_addr,
    input  logic [31:0]       rom_data,
    input  logic              rom_ok,

    output pxl_t              pxl
);

    // Table read port
    logic [TBL_AW-1:0] tbl_addr;
    logic [15:0]       tbl_data;

    // Line buffer writes
    logic              bf_we;
    logic [8:0]        bf_addr;
    pxl_t              bf_data;

    obj_bus_if #(.AW(TBL_AW)) u_bus ();
    obj_cmd_if                u_cmd ();

    // CPU pins onto the bus
    assign u_bus.cyc   = wb_cyc;
    assign u_bus.stb   = wb_stb;
    assign u_bus.we    = wb_we;
    assign u_bus.adr   = wb_adr;
    assign u_bus.dat_w = wb_dat_w;
    assign wb_dat_r    = u_bus.dat_r;
    assign wb_ack      = u_bus.ack;

    obj_table #(.OBJ_COUNT(OBJ_COUNT)) u_table (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .bus      ( u_bus    ),
        .tbl_addr ( tbl_addr ),
        .tbl_data ( tbl_data )
    );

    obj_scan #(.OBJ_COUNT(OBJ_COUNT)) u_scan (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .line_start ( line_start ),
        .line       ( line       ),
        .tbl_addr   ( tbl_addr   ),
        .tbl_data   ( tbl_data   ),
        .cmd        ( u_cmd      )
    );

    obj_draw #(.LINE_W(LINE_W)) u_draw (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .cmd      ( u_cmd    ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .bf_we    ( bf_we    ),
        .bf_addr  ( bf_addr  ),
        .bf_data  ( bf_data  )
    );

    obj_line_buffer #(.LINE_W(LINE_W)) u_line (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .line_start ( line_start ),
        .pxl_cen    ( pxl_cen    ),
        .bf_we      ( bf_we      ),
        .bf_addr    ( bf_addr    ),
        .bf_data    ( bf_data    ),
        .pxl        ( pxl        )
    );

endmodule

`default_nettype wire

//--- verif/obj_engine_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Sprite engine testbench
// Random table and ROM latency, reference line renderer
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module obj_engine_tb
    import obj_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int OBJ_COUNT  = 16;
    localparam int LINE_W     = 256;
    localparam int TBL_AW     = $clog2(OBJ_COUNT * OBJ_WORDS);
    localparam int CLK_PERIOD = 100;
    // Longer than the worst draw time for a full table
    localparam int GAP        = OBJ_COUNT * (4 + 2 * (9 + 8)) + 64;
    localparam int LINE_CYC   = GAP + LINE_W + 10;
    localparam int MAX_LINES  = 40;
    localparam int MAX_WB     = 600;
    localparam longint LIMIT_NS =
        2 * (longint'(MAX_LINES) * LINE_CYC + MAX_WB * 3 + LINE_W) * CLK_PERIOD;

    logic              clk;
    logic              arst_n;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [TBL_AW-1:0] wb_adr;
    logic [15:0]       wb_dat_w;
    logic [15:0]       wb_dat_r;
    logic              wb_ack;
    logic              line_start;
    logic [8:0]        line;
    logic              pxl_cen;
    logic              rom_cs;
    logic [15:0]       rom_addr;
    logic [31:0]       rom_data;
    logic              rom_ok;
    logic [7:0]        pxl;

    int          seed = 47769;
    logic [15:0] tbl_m [OBJ_COUNT * OBJ_WORDS];
    logic [7:0]  exp_front [LINE_W];
    logic [7:0]  exp_back [LINE_W];
    int          front_line = -1;
    int          test_num = 0;
    int          test_err = 0;
    int          test_chk = 0;
    int          total_err = 0;
    int          failed_tests = 0;
    int          rom_wait = 0;
    bit          rom_busy = 1'b0;
    logic [15:0] rom_req_addr;

    obj_engine #(.OBJ_COUNT(OBJ_COUNT), .LINE_W(LINE_W)) u_dut (
        .clk(clk), .arst_n(arst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .line_start(line_start), .line(line), .pxl_cen(pxl_cen),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok),
        .pxl(pxl)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Pixel ROM contents, a hash of the address with about a quarter of nibbles blank
    function automatic logic [31:0] rom_word(input logic [15:0] addr);
        logic [31:0] x;
        logic [31:0] m;
        x = {16'h0, addr} * 32'h9E37_79B1;
        x = x ^ (x >> 13) ^ 32'h5A5A_1234;
        m = x ^ (x >> 7);
        for (int k = 0; k < 8; k++) begin
            if (m[4*k +: 2] == 2'b00) x[4*k +: 4] = 4'h0;
        end
        return x;
    endfunction

    function automatic int urand(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // ROM model, cs/ok with 0 to 7 cycles of wait
    always @(negedge clk) begin
        if (!arst_n || rom_ok) begin
            // cs has to fall on the edge that saw ok
            if (rom_ok) begin
                test_chk++;
                assert (rom_cs === 1'b0) else begin
                    $display("ROM cs still high in the cycle after ok at %0t", $time);
                    test_err++;
                end
            end
            rom_ok   = 1'b0;
            rom_busy = 1'b0;
        end else if (rom_cs && !rom_busy) begin
            rom_busy     = 1'b1;
            rom_wait     = urand(8);
            rom_req_addr = rom_addr;
        end else if (rom_busy) begin
            // Request held with a steady address until ok
            test_chk++;
            assert (rom_cs === 1'b1 && rom_addr === rom_req_addr) else begin
                $display("Mismatch at %0t: ROM request cs %b addr %h, expected cs 1 addr %h",
                         $time, rom_cs, rom_addr, rom_req_addr);
                test_err++;
            end
            rom_wait = rom_wait - 1;
        end
        if (rom_busy && !rom_ok && rom_wait <= 0) begin
            rom_data = rom_word(rom_addr);
            rom_ok   = 1'b1;
        end
    end

    // Ends a run that stalls
    initial begin
        #(LIMIT_NS);
        $display("Watchdog expired, simulation did not finish in time");
        $display("TB FAILED");
        $finish;
    end

    // One Wishbone classic cycle with ack timing checks, model mirrors writes
    task automatic wb_access(input bit we, input int adr, input logic [15:0] wdat,
                             output logic [15:0] rdat);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = TBL_AW'(adr);
        wb_dat_w = wdat;
        if (we) tbl_m[adr] = wdat;
        @(negedge clk);
        test_chk++;
        assert (wb_ack === 1'b1) else begin
            $display("Wishbone ack missing one cycle after stb, address %0d at %0t", adr, $time);
            test_err++;
        end
        rdat = wb_dat_r;
        // stb still held here, ack must already be gone
        @(negedge clk);
        test_chk++;
        assert (wb_ack === 1'b0) else begin
            $display("Wishbone ack held longer than one cycle, address %0d at %0t", adr, $time);
            test_err++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
    endtask

    task automatic wb_write(input int adr, input logic [15:0] wdat);
        logic [15:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic set_entry(input int e, input int y, input int h, input int x,
                             input int pal, input int hf, input int en, input int base);
        wb_write(4 * e + 0, {7'(h), 9'(y)});
        wb_write(4 * e + 1, {1'(en), 1'b0, 1'(hf), 4'(pal), 9'(x)});
        wb_write(4 * e + 2, 16'(base));
        wb_write(4 * e + 3, 16'h0);
    endtask

    task automatic clear_table();
        for (int a = 0; a < OBJ_COUNT * OBJ_WORDS; a++) wb_write(a, 16'h0);
    endtask

    // Reference renderer, last entry first so lower entries overwrite
    task automatic render(input int ln);
        int          row;
        int          pos;
        logic [15:0] w0;
        logic [15:0] w1;
        logic [31:0] word;
        logic [3:0]  colour;
        for (int i = 0; i < LINE_W; i++) exp_back[i] = 8'h00;
        for (int e = OBJ_COUNT - 1; e >= 0; e--) begin
            w0  = tbl_m[4 * e];
            w1  = tbl_m[4 * e + 1];
            row = (ln - int'(w0[8:0])) & 511;
            if (w1[15] && row <= int'(w0[15:9])) begin
                for (int c = 0; c < SPR_W; c++) begin
                    word   = rom_word(16'(int'(tbl_m[4 * e + 2]) + 2 * row + c / 8));
                    colour = word[4 * (c % 8) +: 4];
                    pos    = w1[13] ? int'(w1[8:0]) + SPR_W - 1 - c : int'(w1[8:0]) + c;
                    if (colour != 4'h0 && pos < LINE_W) exp_back[pos] = {w1[12:9], colour};
                end
            end
        end
    endtask

    // Reads the front buffer, beyond LINE_W must read 0
    task automatic read_front();
        logic [7:0] expv;
        pxl_cen = 1'b1;
        for (int i = 0; i < LINE_W + 8; i++) begin
            @(negedge clk);
            expv = (i < LINE_W) ? exp_front[i] : 8'h00;
            test_chk++;
            assert (pxl === expv) else begin
                $display("Mismatch at %0t: line %0d pixel %0d got %h expected %h",
                         $time, front_line, i, pxl, expv);
                test_err++;
            end
        end
        pxl_cen = 1'b0;
    endtask

    // Draws line ln into the back buffer while the previous line is checked
    task automatic run_line(input int ln);
        render(ln);
        line       = 9'(ln);
        line_start = 1'b1;
        @(negedge clk);
        line_start = 1'b0;
        repeat (GAP) @(negedge clk);
        read_front();
        exp_front  = exp_back;
        front_line = ln;
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %0d checks, %0d errors, %s",
                 test_num, name, test_chk, test_err, (test_err == 0) ? "ok" : "bad");
        total_err += test_err;
        if (test_err != 0) failed_tests++;
        test_err = 0;
        test_chk = 0;
    endtask

    initial begin
        logic [15:0] rd;
        logic [15:0] wr;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = 16'h0;
        line_start = 1'b0;
        line       = 9'd0;
        pxl_cen    = 1'b0;
        rom_data   = 32'h0;
        rom_ok     = 1'b0;
        for (int i = 0; i < LINE_W; i++) exp_front[i] = 8'h00;
        arst_n = 1'b0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;

        // Idle outputs, then a blank readout once the clear has run
        test_chk += 2;
        assert (wb_ack === 1'b0 && rom_cs === 1'b0) else begin
            $display("wb_ack or rom_cs not low after reset at %0t", $time);
            test_err += 2;
        end
        repeat (GAP) @(negedge clk);
        read_front();
        end_test("reset state");

        // Every table word written with random data and read back
        for (int a = 0; a < OBJ_COUNT * OBJ_WORDS; a++) wb_write(a, 16'(urand(65536)));
        for (int a = 0; a < OBJ_COUNT * OBJ_WORDS; a++) begin
            wr = tbl_m[a];
            wb_access(1'b0, a, 16'h0, rd);
            test_chk++;
            assert (rd === wr) else begin
                $display("Mismatch at %0t: table word %0d read %h expected %h",
                         $time, a, rd, wr);
                test_err++;
            end
        end
        end_test("table access");

        // One sprite ten rows tall, lines around and inside it
        clear_table();
        set_entry(5, 40, 9, 100, 3, 0, 1, 16'h1200);
        run_line(38);
        run_line(39);
        run_line(40);
        run_line(45);
        run_line(49);
        run_line(50);
        run_line(60);
        end_test("single sprite");

        // Crowded random table
        for (int e = 0; e < OBJ_COUNT; e++) begin
            set_entry(e, 100 + urand(8), urand(12), urand(LINE_W), urand(16), urand(2),
                      int'(urand(4) != 0), urand(65536));
        end
        for (int ln = 100; ln < 112; ln++) run_line(ln);
        end_test("random overlap");

        // Flipped sprites, most of them across or past the right edge
        clear_table();
        for (int e = 0; e < OBJ_COUNT; e++) begin
            set_entry(e, 20 + urand(8), 7 + urand(8),
                      (e < 4) ? urand(200) : LINE_W - 16 + urand(24),
                      urand(16), (e % 4 != 3) ? 1 : 0, 1, urand(65536));
        end
        for (int ln = 20; ln < 28; ln++) run_line(ln);
        end_test("hflip and clip");

        // Busy line, then blank lines that must read back empty
        for (int e = 0; e < OBJ_COUNT; e++) begin
            set_entry(e, 70 - urand(4), 4 + urand(8), urand(LINE_W), urand(16), urand(2),
                      1, urand(65536));
        end
        run_line(70);
        clear_table();
        run_line(71);
        run_line(72);
        end_test("erase on read");

        $display("tests %0d, failed %0d, errors %0d", test_num, failed_tests, total_err);
        if (failed_tests == 0 && total_err == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
verilog/obj_pkg.sv
verilog/obj_ifs.sv
verilog/obj_table.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/obj_line_buffer.sv
verilog/obj_engine.sv
verif/obj_engine_tb.sv

//--- Makefile
# Verilator build and run for the sprite engine

TOP := obj_engine_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

lint:
	verilator --lint-only --timing --top-module obj_engine -f files.f

clean:
	rm -rf obj_dir
